/* commit_defines.svh */
// commit stage widths and port count shared by packages and RTL
`ifndef COMMIT_DEFINES_SVH
`define COMMIT_DEFINES_SVH

// --------------------
// datapath widths
// --------------------
// integer / FP register data width
`define XLEN 32
// program counter width
`define VLEN 32

// --------------------
// commit configuration
// --------------------
// instructions retired per cycle at most
`define NR_COMMIT_PORTS 2
// scoreboard tag width
`define TRANS_ID_BITS 3
// register file address width
`define REG_ADDR_BITS 5
// fflags field, low bits of an FPU cause
`define FFLAGS_BITS 5
// retired instruction counter
`define INSTRET_BITS 64

`endif

/* riscv_pkg.sv */
// architectural types seen by the commit stage: exception record and CSR operation
`include "commit_defines.svh"

package riscv_pkg;

  // --------------------
  // exceptions
  // --------------------
  // cause field spans the whole register, interrupt bit included
  localparam int unsigned CauseWidth = `XLEN;

  typedef logic [CauseWidth-1:0] cause_t;

  // trap record carried down the pipeline
  typedef struct packed {
    logic               valid;
    cause_t             cause;
    logic [`XLEN-1:0]   tval;
  } exception_t;

  // --------------------
  // CSR file access
  // --------------------
  // CSR_NOP leaves the CSR file untouched
  typedef enum logic [2:0] {
    CSR_NOP   = 3'd0,
    CSR_WRITE = 3'd1,
    CSR_SET   = 3'd2,
    CSR_CLEAR = 3'd3,
    CSR_READ  = 3'd4
  } csr_op_t;

endpackage

/* commit_pkg.sv */
// scoreboard types: functional unit, operation code and scoreboard entry
`include "commit_defines.svh"

package commit_pkg;
  import riscv_pkg::*;

  // --------------------
  // functional units
  // --------------------
  typedef enum logic [2:0] {
    NONE, ALU, LOAD, STORE, CTRL_FLOW, MULT, CSR, FPU
  } fu_t;

  // --------------------
  // operation codes
  // --------------------
  // only the encodings commit cares about are spelled out
  typedef enum logic [4:0] {
    ADD, SUB, ANDL, ORL, XORL, SLL, SRL,
    LW, SW, JAL, BEQ, MUL, DIV,
    // CSR accesses, mapped onto csr_op_t at commit
    CSRRW, CSRRS, CSRRC, CSRR,
    // memory ordering
    FENCE, FENCE_I,
    // FP ops with an FP destination
    FADD, FMUL, FMADD, FMV_W_X
  } fu_op_t;

  // one scoreboard slot as presented at the head
  typedef struct packed {
    logic                       valid;
    logic [`VLEN-1:0]           pc;
    logic [`TRANS_ID_BITS-1:0]  trans_id;
    fu_t                        fu;
    fu_op_t                     op;
    logic [`REG_ADDR_BITS-1:0]  rd;
    logic [`XLEN-1:0]           result;
    exception_t                 ex;
    // destination sits in the FP register file
    logic                       rd_is_fpr;
  } scoreboard_entry_t;

endpackage

/* commit_if.sv */
// per-port decoded commit request and writeback control bundles
`timescale 1ns/1ps
`include "commit_defines.svh"

interface commit_port_if import commit_pkg::*; ();
  logic              req_valid;
  logic              drop;
  scoreboard_entry_t entry;
  // classification of the head entry
  logic              is_store;
  logic              is_csr;
  logic              is_fence;
  logic              is_fence_i;
  logic              is_fpu;
  logic              writes_fpr;
  logic              has_ex;
  // unit may retire on the second port
  logic              dual_ok;

  modport dec (output req_valid, drop, entry, is_store, is_csr, is_fence, is_fence_i,
               is_fpu, writes_fpr, has_ex, dual_ok);
  modport ctrl (input req_valid, drop, entry, is_store, is_csr, is_fence, is_fence_i,
                is_fpu, writes_fpr, has_ex, dual_ok);
  modport exc (input drop, entry);
  modport wb (input req_valid, entry, is_csr, is_fpu, writes_fpr, has_ex);
endinterface

interface commit_wb_if ();
  logic [`NR_COMMIT_PORTS-1:0] ack;
  logic [`NR_COMMIT_PORTS-1:0] we_gpr;
  logic [`NR_COMMIT_PORTS-1:0] we_fpr;
  logic [`NR_COMMIT_PORTS-1:0] fflags_we;
  // port 0 writes back the CSR read value
  logic                        use_csr_rdata;

  modport ctrl (output ack, we_gpr, we_fpr, fflags_we, use_csr_rdata);
  modport wb (input ack, we_gpr, we_fpr, fflags_we, use_csr_rdata);
endinterface

/* commit_decode.sv */
// commit decode: classifies one scoreboard head entry into commit flags
`timescale 1ns/1ps

module commit_decode
  import commit_pkg::*;
(
  input  scoreboard_entry_t commit_instr_i,
  input  logic              commit_drop_i,
  input  logic              halt_i,
  commit_port_if.dec        port_o
);

  // --------------------
  // request
  // --------------------
  // a halt hides the entry from every commit decision
  assign port_o.req_valid = commit_instr_i.valid & ~halt_i;
  assign port_o.drop      = commit_drop_i;
  assign port_o.entry     = commit_instr_i;

  // --------------------
  // classification
  // --------------------
  assign port_o.is_store   = (commit_instr_i.fu == STORE);
  assign port_o.is_csr     = (commit_instr_i.fu == CSR);
  assign port_o.is_fpu     = (commit_instr_i.fu == FPU);
  // fences are told apart by opcode, not by unit
  assign port_o.is_fence   = (commit_instr_i.op == FENCE);
  assign port_o.is_fence_i = (commit_instr_i.op == FENCE_I);
  assign port_o.writes_fpr = commit_instr_i.rd_is_fpr;
  assign port_o.has_ex     = commit_instr_i.ex.valid;

  // simple units without side effects beyond the register file
  assign port_o.dual_ok = commit_instr_i.fu inside {ALU, LOAD, CTRL_FLOW, MULT, FPU};

endmodule

/* commit_ctrl.sv */
// commit control: acks, register write enables, LSU/CSR commit and fence requests
`timescale 1ns/1ps

module commit_ctrl
  import riscv_pkg::*;
  import commit_pkg::*;
(
  commit_port_if.ctrl port0_i,
  commit_port_if.ctrl port1_i,
  input  logic        single_step_i,
  input  logic        commit_lsu_ready_i,
  input  logic        no_st_pending_i,
  input  logic        csr_exc_valid_i,
  output logic        commit_lsu_o,
  output logic        commit_csr_o,
  output logic        fence_o,
  output logic        fence_i_o,
  output csr_op_t     csr_op_o,
  commit_wb_if.ctrl   ctrl_o
);

  logic ack0;
  logic ack1;
  // port 0 holds a valid entry without its own exception
  logic clean0;
  logic keep0;

  assign clean0 = port0_i.req_valid & ~port0_i.has_ex;
  assign keep0  = clean0 & ~port0_i.drop;

  // --------------------
  // port 0
  // --------------------
  always_comb begin
    ack0 = 1'b0;
    if (port0_i.req_valid) begin
      if (port0_i.has_ex) begin
        // faulting entry leaves only when it is thrown away
        ack0 = port0_i.drop;
      end else begin
        ack0 = 1'b1;
        // store buffer full
        if (port0_i.is_store && !commit_lsu_ready_i)
          ack0 = 1'b0;
        // CSR file raised a trap on this access
        if (port0_i.is_csr && !port0_i.drop && csr_exc_valid_i)
          ack0 = 1'b0;
        // drain the store buffer before any fence
        if ((port0_i.is_fence || port0_i.is_fence_i) && !port0_i.drop && !no_st_pending_i)
          ack0 = 1'b0;
      end
    end
  end

  // store goes to the store buffer once the LSU takes it
  assign commit_lsu_o = clean0 & port0_i.is_store & commit_lsu_ready_i;
  assign commit_csr_o = keep0 & port0_i.is_csr & ~csr_exc_valid_i;
  assign fence_o      = keep0 & port0_i.is_fence & no_st_pending_i;
  assign fence_i_o    = keep0 & port0_i.is_fence_i & no_st_pending_i;

  // scoreboard op to CSR file op, NOP when nothing CSR is at the head
  always_comb begin
    csr_op_o = CSR_NOP;
    if (clean0 && port0_i.is_csr) begin
      case (port0_i.entry.op)
        CSRRW:   csr_op_o = CSR_WRITE;
        CSRRS:   csr_op_o = CSR_SET;
        CSRRC:   csr_op_o = CSR_CLEAR;
        CSRR:    csr_op_o = CSR_READ;
        default: csr_op_o = CSR_NOP;
      endcase
    end
  end

  // --------------------
  // port 1
  // --------------------
  // rides along with port 0, never behind a CSR access or in debug stepping
  assign ack1 = ack0 & port1_i.req_valid & ~port0_i.is_csr & ~single_step_i
              & ~port1_i.has_ex & port1_i.dual_ok;

  // --------------------
  // writeback control
  // --------------------
  assign ctrl_o.ack = {ack1, ack0};

  // dropped or faulting entries never touch the register files
  assign ctrl_o.we_gpr[0] = ack0 & keep0 & ~port0_i.writes_fpr;
  assign ctrl_o.we_fpr[0] = ack0 & keep0 & port0_i.writes_fpr;
  assign ctrl_o.we_gpr[1] = ack1 & ~port1_i.drop & ~port1_i.writes_fpr;
  assign ctrl_o.we_fpr[1] = ack1 & ~port1_i.drop & port1_i.writes_fpr;

  // accrued FP flags from retiring FPU ops
  assign ctrl_o.fflags_we[0] = ack0 & keep0 & port0_i.is_fpu;
  assign ctrl_o.fflags_we[1] = ack1 & ~port1_i.drop & port1_i.is_fpu;

  assign ctrl_o.use_csr_rdata = commit_csr_o;

endmodule

/* commit_exception.sv */
// commit exception select: picks the trap taken by the port 0 head entry
`timescale 1ns/1ps

module commit_exception
  import riscv_pkg::*;
(
  commit_port_if.exc port0_i,
  input  exception_t csr_exception_i,
  input  logic       halt_i,
  output exception_t exception_o
);

  always_comb begin
    exception_o = '0;

    // only a live, non-dropped head can trap
    if (port0_i.entry.valid && !port0_i.drop) begin
      // --------------------
      // CSR file trap
      // --------------------
      if (csr_exception_i.valid) begin
        exception_o = csr_exception_i;
        // tval still holds the instruction bits from decode
        exception_o.tval = port0_i.entry.ex.tval;
      end

      // --------------------
      // earlier trap
      // --------------------
      // fetch/decode faults happened first, so they win
      if (port0_i.entry.ex.valid)
        exception_o = port0_i.entry.ex;
    end

    // debug halt takes nothing
    if (halt_i)
      exception_o.valid = 1'b0;
  end

endmodule

/* commit_writeback.sv */
// commit writeback: register write data, FP flags, FP dirty flag and instret counter
`timescale 1ns/1ps
`include "commit_defines.svh"

module commit_writeback (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  commit_port_if.wb                                        port0_i,
  commit_port_if.wb                                        port1_i,
  commit_wb_if.wb                                          ctrl_i,
  input  logic [`XLEN-1:0]                                 csr_rdata_i,
  output logic [`NR_COMMIT_PORTS-1:0][`REG_ADDR_BITS-1:0]  waddr_o,
  output logic [`NR_COMMIT_PORTS-1:0][`XLEN-1:0]           wdata_o,
  output logic [`NR_COMMIT_PORTS-1:0]                      we_gpr_o,
  output logic [`NR_COMMIT_PORTS-1:0]                      we_fpr_o,
  output logic [`XLEN-1:0]                                 csr_wdata_o,
  output logic                                             csr_write_fflags_o,
  output logic                                             dirty_fp_state_o,
  output logic [`INSTRET_BITS-1:0]                         instret_o
);

  logic [`FFLAGS_BITS-1:0]               fflags;
  logic [$clog2(`NR_COMMIT_PORTS+1)-1:0] ack_cnt;

  // --------------------
  // register writeback
  // --------------------
  assign waddr_o  = {port1_i.entry.rd, port0_i.entry.rd};
  // a committed CSR access returns the old CSR value
  assign wdata_o  = {port1_i.entry.result,
                     ctrl_i.use_csr_rdata ? csr_rdata_i : port0_i.entry.result};
  assign we_gpr_o = ctrl_i.we_gpr;
  assign we_fpr_o = ctrl_i.we_fpr;

  // --------------------
  // CSR write data
  // --------------------
  assign csr_write_fflags_o = |ctrl_i.fflags_we;

  always_comb begin
    fflags = '0;
    // merge flags when both ports retire FPU ops
    if (ctrl_i.fflags_we[0])
      fflags |= port0_i.entry.ex.cause[`FFLAGS_BITS-1:0];
    if (ctrl_i.fflags_we[1])
      fflags |= port1_i.entry.ex.cause[`FFLAGS_BITS-1:0];

    csr_wdata_o = '0;
    if (port0_i.req_valid && !port0_i.has_ex && port0_i.is_csr)
      csr_wdata_o = port0_i.entry.result;
    if (csr_write_fflags_o)
      csr_wdata_o = {{(`XLEN-`FFLAGS_BITS){1'b0}}, fflags};
  end

  // mstatus.FS goes dirty on any retired FP work
  assign dirty_fp_state_o = (ctrl_i.ack[0] & (port0_i.is_fpu | port0_i.writes_fpr))
                          | (ctrl_i.ack[1] & (port1_i.is_fpu | port1_i.writes_fpr));

  // --------------------
  // instret
  // --------------------
  always_comb begin
    ack_cnt = '0;
    for (int i = 0; i < `NR_COMMIT_PORTS; i++)
      ack_cnt += ctrl_i.ack[i];
  end

  always_ff @(posedge clk_i) begin
    if (rst_i)
      instret_o <= '0;
    else
      instret_o <= instret_o + `INSTRET_BITS'(ack_cnt);
  end

endmodule

/* commit_stage.sv */
// commit stage top: retires up to two scoreboard head entries per cycle
`timescale 1ns/1ps
`include "commit_defines.svh"

module commit_stage
  import riscv_pkg::*;
  import commit_pkg::*;
(
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  input  logic                                             halt_i,
  input  logic                                             single_step_i,
  // scoreboard head
  input  scoreboard_entry_t [`NR_COMMIT_PORTS-1:0]         commit_instr_i,
  input  logic [`NR_COMMIT_PORTS-1:0]                      commit_drop_i,
  output logic [`NR_COMMIT_PORTS-1:0]                      commit_ack_o,
  // register files
  output logic [`NR_COMMIT_PORTS-1:0][`REG_ADDR_BITS-1:0]  waddr_o,
  output logic [`NR_COMMIT_PORTS-1:0][`XLEN-1:0]           wdata_o,
  output logic [`NR_COMMIT_PORTS-1:0]                      we_gpr_o,
  output logic [`NR_COMMIT_PORTS-1:0]                      we_fpr_o,
  output logic [`VLEN-1:0]                                 pc_o,
  output logic [`TRANS_ID_BITS-1:0]                        commit_tran_id_o,
  // CSR file
  output csr_op_t                                          csr_op_o,
  output logic [`XLEN-1:0]                                 csr_wdata_o,
  output logic                                             csr_write_fflags_o,
  output logic                                             commit_csr_o,
  input  logic [`XLEN-1:0]                                 csr_rdata_i,
  input  exception_t                                       csr_exception_i,
  // load-store unit
  output logic                                             commit_lsu_o,
  input  logic                                             commit_lsu_ready_i,
  input  logic                                             no_st_pending_i,
  // controller
  output logic                                             fence_o,
  output logic                                             fence_i_o,
  output exception_t                                       exception_o,
  output logic                                             dirty_fp_state_o,
  output logic [`INSTRET_BITS-1:0]                         instret_o
);

  commit_port_if port_if [`NR_COMMIT_PORTS] ();
  commit_wb_if   wb_if ();

  // --------------------
  // decode per port
  // --------------------
  for (genvar i = 0; i < `NR_COMMIT_PORTS; i++) begin : gen_decode
    commit_decode i_decode (
      .commit_instr_i (commit_instr_i[i]),
      .commit_drop_i  (commit_drop_i[i]),
      .halt_i         (halt_i),
      .port_o         (port_if[i])
    );
  end

  // --------------------
  // commit decisions
  // --------------------
  commit_ctrl i_ctrl (
    .port0_i            (port_if[0]),
    .port1_i            (port_if[1]),
    .single_step_i      (single_step_i),
    .commit_lsu_ready_i (commit_lsu_ready_i),
    .no_st_pending_i    (no_st_pending_i),
    .csr_exc_valid_i    (csr_exception_i.valid),
    .commit_lsu_o       (commit_lsu_o),
    .commit_csr_o       (commit_csr_o),
    .fence_o            (fence_o),
    .fence_i_o          (fence_i_o),
    .csr_op_o           (csr_op_o),
    .ctrl_o             (wb_if)
  );

  commit_exception i_exception (
    .port0_i         (port_if[0]),
    .csr_exception_i (csr_exception_i),
    .halt_i          (halt_i),
    .exception_o     (exception_o)
  );

  commit_writeback i_writeback (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .port0_i            (port_if[0]),
    .port1_i            (port_if[1]),
    .ctrl_i             (wb_if),
    .csr_rdata_i        (csr_rdata_i),
    .waddr_o            (waddr_o),
    .wdata_o            (wdata_o),
    .we_gpr_o           (we_gpr_o),
    .we_fpr_o           (we_fpr_o),
    .csr_wdata_o        (csr_wdata_o),
    .csr_write_fflags_o (csr_write_fflags_o),
    .dirty_fp_state_o   (dirty_fp_state_o),
    .instret_o          (instret_o)
  );

  // head entry identifies the instruction for the frontend and scoreboard
  assign pc_o             = port_if[0].entry.pc;
  assign commit_tran_id_o = port_if[0].entry.trans_id;
  assign commit_ack_o     = wb_if.ack;

endmodule

/* tb_clock.sv */
// testbench clock and power-on reset source
`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_o
);

  // free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // reset held for a fixed number of rising edges
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

/* tb_commit_stage.sv */
// commit stage testbench with random head entries checked against a reference model
`timescale 1ns/1ps
`include "commit_defines.svh"

module tb_commit_stage
  import riscv_pkg::*;
  import commit_pkg::*;
();

  // test phases that each bias the random stimulus
  localparam int T_DUAL = 0;
  localparam int T_MEM  = 1;
  localparam int T_CSR  = 2;
  localparam int T_EXC  = 3;
  localparam int T_FP   = 4;
  localparam int T_MIX  = 5;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 400;
  // all test cycles plus reset and a margin at 4 ns per cycle
  localparam int WATCHDOG_NS = (NUM_TESTS * CYCLES_PER_TEST + 4 + 100) * 4;

  string test_name [NUM_TESTS] = '{"dual_retire", "store_fence", "csr_commit",
                                   "exceptions", "fp_flags", "mixed"};

  logic clk;
  logic rst;

  // DUT inputs
  logic                                    halt;
  logic                                    single_step;
  scoreboard_entry_t [`NR_COMMIT_PORTS-1:0] instr;
  logic [`NR_COMMIT_PORTS-1:0]             drop;
  logic [`XLEN-1:0]                        csr_rdata;
  exception_t                              csr_exc;
  logic                                    lsu_ready;
  logic                                    no_st_pending;

  // DUT outputs
  logic [`NR_COMMIT_PORTS-1:0]                     ack;
  logic [`NR_COMMIT_PORTS-1:0][`REG_ADDR_BITS-1:0] waddr;
  logic [`NR_COMMIT_PORTS-1:0][`XLEN-1:0]          wdata;
  logic [`NR_COMMIT_PORTS-1:0]                     we_gpr;
  logic [`NR_COMMIT_PORTS-1:0]                     we_fpr;
  logic [`VLEN-1:0]                                pc;
  logic [`TRANS_ID_BITS-1:0]                       tran_id;
  csr_op_t                                         csr_op;
  logic [`XLEN-1:0]                                csr_wdata;
  logic                                            csr_fflags;
  logic                                            commit_csr;
  logic                                            commit_lsu;
  logic                                            fence;
  logic                                            fence_i;
  exception_t                                      exc;
  logic                                            dirty_fp;
  logic [`INSTRET_BITS-1:0]                        instret;

  int          errors = 0;
  int          checks = 0;
  logic [63:0] model_instret = '0;
  logic [31:0] rng_state = 32'h2b6c_588d;

  tb_clock i_clock (
    .clk_o (clk),
    .rst_o (rst)
  );

  commit_stage UUT (
    .clk_i (clk), .rst_i (rst), .halt_i (halt), .single_step_i (single_step),
    .commit_instr_i (instr), .commit_drop_i (drop), .commit_ack_o (ack),
    .waddr_o (waddr), .wdata_o (wdata), .we_gpr_o (we_gpr), .we_fpr_o (we_fpr),
    .pc_o (pc), .commit_tran_id_o (tran_id), .csr_op_o (csr_op),
    .csr_wdata_o (csr_wdata), .csr_write_fflags_o (csr_fflags),
    .commit_csr_o (commit_csr), .csr_rdata_i (csr_rdata), .csr_exception_i (csr_exc),
    .commit_lsu_o (commit_lsu), .commit_lsu_ready_i (lsu_ready),
    .no_st_pending_i (no_st_pending), .fence_o (fence), .fence_i_o (fence_i),
    .exception_o (exc), .dirty_fp_state_o (dirty_fp), .instret_o (instret)
  );

  // --------------------
  // random source
  // --------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // true about once in n calls
  function automatic logic chance(input int unsigned n);
    return (next_rand() % n) == 0;
  endfunction

  // --------------------
  // stimulus
  // --------------------
  function automatic fu_t pick_fu(input int mode, input int port);
    fu_t         simple [5];
    logic [31:0] r;
    simple = '{ALU, LOAD, CTRL_FLOW, MULT, FPU};
    r = next_rand();
    if (mode == T_EXC || mode == T_MIX) return fu_t'(r[2:0]);
    if (mode == T_FP) return FPU;
    if (port == 0 && mode == T_MEM) return r[8] ? STORE : NONE;
    if (port == 0 && mode == T_CSR) return CSR;
    // occasional CSR on port 0 to block the second port
    if (port == 0 && mode == T_DUAL && r[7:5] == 3'd0) return CSR;
    return simple[r[31:16] % 5];
  endfunction

  function automatic scoreboard_entry_t make_entry(input fu_t fu, input logic ex_on);
    scoreboard_entry_t e;
    logic [31:0]       r;
    r = next_rand();
    e = '0;
    e.valid    = 1'b1;
    e.pc       = next_rand() & 32'hffff_fffc;
    e.trans_id = r[2:0];
    e.rd       = r[7:3];
    e.fu       = fu;
    e.result   = next_rand();
    // FPU flags ride in the low cause bits
    e.ex.cause = next_rand();
    e.ex.tval  = next_rand();
    e.ex.valid = ex_on;
    case (fu)
      ALU:       e.op = r[8] ? ADD : XORL;
      LOAD:      e.op = LW;
      STORE:     e.op = SW;
      CTRL_FLOW: e.op = r[8] ? JAL : BEQ;
      MULT:      e.op = r[8] ? MUL : DIV;
      CSR:       e.op = fu_op_t'(int'(CSRRW) + int'(r[9:8]));
      FPU:       e.op = r[8] ? FADD : FMV_W_X;
      default:   e.op = r[8] ? FENCE : FENCE_I;
    endcase
    e.rd_is_fpr = (fu == FPU || fu == LOAD) && r[10];
    return e;
  endfunction

  task automatic drive_cycle(input int mode);
    scoreboard_entry_t e [`NR_COMMIT_PORTS];
    logic [`NR_COMMIT_PORTS-1:0] d;
    exception_t ce;
    int ex_odds;
    int drop_odds;
    ex_odds   = (mode == T_EXC) ? 2 : (mode == T_MIX) ? 6 : 0;
    drop_odds = (mode == T_EXC) ? 2 : (mode == T_FP) ? 16 : 8;
    for (int p = 0; p < `NR_COMMIT_PORTS; p++) begin
      e[p] = make_entry(pick_fu(mode, p), ex_odds != 0 && chance(ex_odds));
      if (mode == T_MIX && chance(4))
        e[p].valid = 1'b0;
      d[p] = chance(drop_odds);
    end
    ce.valid = (mode == T_CSR) ? chance(3) : (mode == T_EXC) ? chance(4)
             : (mode == T_MIX) ? chance(8) : 1'b0;
    ce.cause = next_rand();
    ce.tval  = next_rand();
    instr         <= {e[1], e[0]};
    drop          <= d;
    csr_exc       <= ce;
    csr_rdata     <= next_rand();
    halt          <= (mode == T_EXC) ? chance(4) : (mode == T_MIX) ? chance(10) : 1'b0;
    single_step   <= (mode == T_DUAL) ? chance(4) : (mode == T_MIX) ? chance(10) : 1'b0;
    lsu_ready     <= (mode == T_MEM || mode == T_MIX) ? chance(2) : 1'b1;
    no_st_pending <= (mode == T_MEM || mode == T_MIX) ? chance(2) : 1'b1;
  endtask

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_vec(input string test, input string sig,
                           input logic [63:0] expv, input logic [63:0] actv);
    checks++;
    if (actv !== expv) begin
      errors++;
      $display("FAIL %s %s expected %h actual %h", test, sig, expv, actv);
    end
  endtask

  task automatic check_exc(input string test, input exception_t expv, input exception_t actv);
    checks++;
    if (actv !== expv) begin
      errors++;
      $display("FAIL %s exception_o expected %h actual %h", test, expv, actv);
    end
  endtask

  task automatic check_csr_op(input string test, input csr_op_t expv, input csr_op_t actv);
    checks++;
    if (actv !== expv) begin
      errors++;
      $display("FAIL %s csr_op_o expected %0d actual %0d", test, expv, actv);
    end
  endtask

  // --------------------
  // reference model
  // --------------------
  task automatic check_outputs(input string test);
    logic v0, v1, ok0, k0, a0, a1, k1, ff0, ff1, csr_go;
    logic [`FFLAGS_BITS-1:0] flags;
    logic [`XLEN-1:0]        exp_wdata;
    csr_op_t                 exp_op;
    exception_t              exp_exc;
    // halt hides both entries
    v0  = instr[0].valid && !halt;
    v1  = instr[1].valid && !halt;
    ok0 = v0 && !instr[0].ex.valid;
    k0  = ok0 && !drop[0];
    // port 0 with an exception leaves only when dropped
    if (!v0)
      a0 = 1'b0;
    else if (instr[0].ex.valid)
      a0 = drop[0];
    else
      a0 = !(instr[0].fu == STORE && !lsu_ready)
        && !(instr[0].fu == CSR && !drop[0] && csr_exc.valid)
        && !(instr[0].op inside {FENCE, FENCE_I} && !drop[0] && !no_st_pending);
    // port 1 follows port 0 with simple units only
    a1 = a0 && v1 && instr[0].fu != CSR && !single_step && !instr[1].ex.valid
      && instr[1].fu inside {ALU, LOAD, CTRL_FLOW, MULT, FPU};
    k1     = a1 && !drop[1];
    ff0    = a0 && k0 && instr[0].fu == FPU;
    ff1    = k1 && instr[1].fu == FPU;
    csr_go = k0 && instr[0].fu == CSR && !csr_exc.valid;
    exp_op = CSR_NOP;
    if (ok0 && instr[0].fu == CSR)
      case (instr[0].op)
        CSRRW:   exp_op = CSR_WRITE;
        CSRRS:   exp_op = CSR_SET;
        CSRRC:   exp_op = CSR_CLEAR;
        default: exp_op = CSR_READ;
      endcase
    flags = (ff0 ? instr[0].ex.cause[`FFLAGS_BITS-1:0] : '0)
          | (ff1 ? instr[1].ex.cause[`FFLAGS_BITS-1:0] : '0);
    exp_wdata = (ok0 && instr[0].fu == CSR) ? instr[0].result : '0;
    if (ff0 || ff1)
      exp_wdata = {{(`XLEN-`FFLAGS_BITS){1'b0}}, flags};
    // own exception beats a CSR trap carrying the entry tval
    exp_exc = '0;
    if (instr[0].valid && !drop[0]) begin
      if (csr_exc.valid) begin
        exp_exc      = csr_exc;
        exp_exc.tval = instr[0].ex.tval;
      end
      if (instr[0].ex.valid)
        exp_exc = instr[0].ex;
    end
    if (halt)
      exp_exc.valid = 1'b0;

    check_vec(test, "commit_ack_o", {a1, a0}, ack);
    check_vec(test, "we_gpr_o", {k1 && !instr[1].rd_is_fpr, k0 && a0 && !instr[0].rd_is_fpr},
              we_gpr);
    check_vec(test, "we_fpr_o", {k1 && instr[1].rd_is_fpr, k0 && a0 && instr[0].rd_is_fpr},
              we_fpr);
    check_vec(test, "waddr_o", {instr[1].rd, instr[0].rd}, waddr);
    check_vec(test, "wdata_o", {instr[1].result, csr_go ? csr_rdata : instr[0].result}, wdata);
    check_vec(test, "pc_o", instr[0].pc, pc);
    check_vec(test, "commit_tran_id_o", instr[0].trans_id, tran_id);
    check_vec(test, "commit_csr_o", csr_go, commit_csr);
    check_vec(test, "commit_lsu_o", ok0 && instr[0].fu == STORE && lsu_ready, commit_lsu);
    check_vec(test, "fence_o", k0 && instr[0].op == FENCE && no_st_pending, fence);
    check_vec(test, "fence_i_o", k0 && instr[0].op == FENCE_I && no_st_pending, fence_i);
    check_vec(test, "csr_write_fflags_o", ff0 || ff1, csr_fflags);
    check_vec(test, "csr_wdata_o", exp_wdata, csr_wdata);
    check_vec(test, "dirty_fp_state_o",
              (a0 && (instr[0].fu == FPU || instr[0].rd_is_fpr))
              || (a1 && (instr[1].fu == FPU || instr[1].rd_is_fpr)), dirty_fp);
    check_csr_op(test, exp_op, csr_op);
    check_exc(test, exp_exc, exc);
    // counter lags the acks by one edge
    check_vec(test, "instret_o", model_instret, instret);
    model_instret = model_instret + a0 + a1;
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    halt          = 1'b0;
    single_step   = 1'b0;
    instr         = '0;
    drop          = '0;
    csr_rdata     = '0;
    csr_exc       = '0;
    lsu_ready     = 1'b1;
    no_st_pending = 1'b1;
    @(negedge rst);
    for (int t = 0; t < NUM_TESTS; t++) begin
      for (int c = 0; c < CYCLES_PER_TEST; c++) begin
        @(posedge clk);
        drive_cycle(t);
        // outputs settled mid-cycle
        @(negedge clk);
        check_outputs(test_name[t]);
      end
    end
    $display("errors=%0d checks=%0d", errors, checks);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* sim.f */
+incdir+.
riscv_pkg.sv
commit_pkg.sv
commit_if.sv
commit_decode.sv
commit_ctrl.sv
commit_exception.sv
commit_writeback.sv
commit_stage.sv
tb_clock.sv
tb_commit_stage.sv

/* Bender.yml */
package:
  name: commit_stage

sources:
  - include_dirs:
      - .
    files:
      - riscv_pkg.sv
      - commit_pkg.sv
      - commit_if.sv
      - commit_decode.sv
      - commit_ctrl.sv
      - commit_exception.sv
      - commit_writeback.sv
      - commit_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock.sv
      - tb_commit_stage.sv
